// ==== flist.f ====
+incdir+src
+incdir+tb
src/ecc_pkg.sv
src/secded_61_codec.sv
src/ecc_word_ram.sv
src/ecc_csr.sv
src/ecc_mem_ctrl.sv
src/ecc_mem_top.sv
tb/tb_ecc_mem.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the ECC store testbench with Verilator, run it, and judge the log.
set -u
cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing -Wno-fatal -f flist.f --top-module tb_ecc_mem \
    --Mdir "$BUILD_DIR" -o sim_tb
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$BUILD_DIR/sim_tb" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "NO ERRORS" "$LOG"; then
    echo "Simulation passed"
    exit 0
fi
echo "Simulation failed"
exit 1

// ==== tb/ecc_ref_model.svh ====
`ifndef ECC_REF_MODEL_SVH
`define ECC_REF_MODEL_SVH

// Expected contents and register state of the store.
cw_t        model_mem [64];
int         position [61];  // Hamming position of each data bit.
chk_t       column [61];    // Syndrome that a flip of each data bit gives.
logic       model_bypass;
logic       model_arm;
logic [6:0] model_pos0;
logic [6:0] model_pos1;
cnt_t       model_sbit_cnt;
cnt_t       model_dbit_cnt;
addr_t      model_err_addr;
logic       model_err_vld;

function automatic chk_t check_bits(input data_t d);
    chk_t c;
    c = '0;
    for (int i = 0; i < 61; i++) begin
        if (d[i]) begin
            c[6:0] = c[6:0] ^ 7'(position[i]);
        end
    end
    c[7] = ^{d, c[6:0]};  // Overall parity.
    return c;
endfunction

function automatic cw_t inject_flips(input cw_t cw);
    cw_t r;
    r = cw;
    if (model_pos0 < 7'd69) begin
        r[model_pos0] = ~r[model_pos0];
    end
    if (model_pos1 < 7'd69) begin
        r[model_pos1] = ~r[model_pos1];  // Same index cancels.
    end
    return r;
endfunction

task automatic reset_model();
    int p;
    int n;
    n = 0;
    for (p = 3; n < 61; p++) begin
        if ((p & (p - 1)) != 0) begin
            position[n] = p;
            n++;
        end
    end
    for (int i = 0; i < 61; i++) begin
        column[i] = check_bits(data_t'(1) << i);
    end
    model_bypass   = 1'b0;
    model_arm      = 1'b0;
    model_pos0     = 7'h7f;
    model_pos1     = 7'h7f;
    model_sbit_cnt = '0;
    model_dbit_cnt = '0;
    model_err_addr = '0;
    model_err_vld  = 1'b0;
endtask

task automatic decode_word(input cw_t cw, input logic byp, output data_t data,
                           output logic sbit, output logic dbit);
    chk_t syn;
    syn  = cw[68:61] ^ check_bits(cw[60:0]);
    data = cw[60:0];
    sbit = 1'b0;
    dbit = 1'b0;
    if (!byp && syn != '0) begin
        dbit = 1'b1;
        if ($countones(syn) == 1) begin
            sbit = 1'b1;  // Flipped check bit.
            dbit = 1'b0;
        end
        for (int i = 0; i < 61; i++) begin
            if (syn == column[i]) begin
                data[i] = ~data[i];
                sbit    = 1'b1;
                dbit    = 1'b0;
            end
        end
    end
endtask

task automatic count_error(input logic sbit, input logic dbit, input addr_t a);
    if (sbit && model_sbit_cnt != '1) begin
        model_sbit_cnt = model_sbit_cnt + 16'd1;
    end
    if (dbit && model_dbit_cnt != '1) begin
        model_dbit_cnt = model_dbit_cnt + 16'd1;
    end
    if (sbit || dbit) begin
        model_err_addr = a;
        model_err_vld  = 1'b1;
    end
endtask

task automatic apply_cfg_write(input csr_addr_t a, input logic [31:0] v);
    case (a)
        CSR_CTRL: begin
            model_bypass = v[0];
            model_arm    = v[1];
        end
        CSR_INJ: begin
            model_pos0 = v[6:0];
            model_pos1 = v[14:8];
        end
        CSR_SBIT_CNT: model_sbit_cnt = '0;
        CSR_DBIT_CNT: model_dbit_cnt = '0;
        default: ;
    endcase
endtask

function automatic logic [31:0] csr_value(input csr_addr_t a);
    logic [31:0] v;
    v = 32'd0;
    case (a)
        CSR_CTRL:     v[1:0] = {model_arm, model_bypass};
        CSR_INJ: begin
            v[6:0]  = model_pos0;
            v[14:8] = model_pos1;
        end
        CSR_SBIT_CNT: v[15:0] = model_sbit_cnt;
        CSR_DBIT_CNT: v[15:0] = model_dbit_cnt;
        CSR_LAST_ERR: begin
            v[31]  = model_err_vld;
            v[5:0] = model_err_addr;
        end
        default:      v = 32'd0;
    endcase
    return v;
endfunction

`endif

// ==== tb/tb_ecc_mem.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_ecc_mem;

    import ecc_pkg::*;

    typedef struct packed {
        logic [31:0] cyc;
        data_t       data;
        logic        sbit;
        logic        dbit;
        addr_t       addr;
    } read_exp_t;

    logic        clk;
    logic        rst;
    logic        wr_req;
    addr_t       wr_addr;
    data_t       wr_data;
    logic        rd_req;
    addr_t       rd_addr;
    logic        rd_valid;
    data_t       rd_data;
    logic        sbit_err;
    logic        dbit_err;
    logic        cfg_wr;
    logic        cfg_rd;
    csr_addr_t   cfg_addr;
    logic [31:0] cfg_wdata;
    logic        cfg_rvalid;
    logic [31:0] cfg_rdata;

    integer      seed;
    logic [31:0] cyc;
    int          checks;
    int          errors;
    read_exp_t   exp_q [$];
    event        run_aborted;

    `include "ecc_ref_model.svh"

    ecc_mem_top dut (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cyc <= cyc + 32'd1;
    end

    initial begin
        @(run_aborted);
        $display("ERRORS FOUND");
        $finish;
    end

    task automatic report_mismatch(input string name, input logic [63:0] expv,
                                   input logic [63:0] got);
        errors++;
        $display("[FAIL] t=%0t %s expected %h got %h", $time, name, expv, got);
    endtask

    task automatic abort_on_timeout(input string what);
        errors++;
        $display("Timeout at t=%0t: %s", $time, what);
        -> run_aborted;
        @(posedge clk);
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    function automatic data_t rand_data();
        return data_t'({$random(seed), $random(seed)});
    endfunction

    function automatic addr_t rand_addr();
        return addr_t'($random(seed));
    endfunction

    task automatic write_word(input addr_t a, input data_t d);
        cw_t cw;
        cw = {check_bits(d), d};
        if (model_arm) begin
            cw        = inject_flips(cw);
            model_arm = 1'b0;  // One-shot.
        end
        model_mem[a] = cw;
        wr_req  = 1'b1;
        wr_addr = a;
        wr_data = d;
        next_cycle();
        wr_req = 1'b0;
    endtask

    task automatic queue_read(input addr_t a);
        read_exp_t e;
        data_t     d;
        logic      s;
        logic      b;
        decode_word(model_mem[a], model_bypass, d, s, b);
        e.cyc  = cyc;
        e.addr = a;
        e.data = d;
        e.sbit = s;
        e.dbit = b;
        exp_q.push_back(e);
        rd_req  = 1'b1;
        rd_addr = a;
    endtask

    task automatic read_word(input addr_t a);
        queue_read(a);
        next_cycle();
        rd_req = 1'b0;
    endtask

    // Old word comes back, so the expectation is taken before the write.
    task automatic write_and_read(input addr_t a, input data_t d);
        queue_read(a);
        write_word(a, d);
        rd_req = 1'b0;
    endtask

    task automatic drain_reads();
        int n;
        n = 0;
        while (exp_q.size() != 0 && n < 50) begin
            next_cycle();
            n++;
        end
        if (exp_q.size() != 0) begin
            abort_on_timeout("read data never came back for all issued reads");
        end
        next_cycle();
    endtask

    task automatic cfg_write(input csr_addr_t a, input logic [31:0] v);
        apply_cfg_write(a, v);
        cfg_wr    = 1'b1;
        cfg_addr  = a;
        cfg_wdata = v;
        next_cycle();
        cfg_wr = 1'b0;
    endtask

    task automatic cfg_read_check(input csr_addr_t a, input string name);
        logic [31:0] expv;
        int          n;
        expv     = csr_value(a);
        cfg_rd   = 1'b1;
        cfg_addr = a;
        next_cycle();
        cfg_rd = 1'b0;
        n      = 0;
        while (!cfg_rvalid && n < 20) begin
            next_cycle();
            n++;
        end
        if (!cfg_rvalid) begin
            abort_on_timeout("cfg_rvalid never came back for a register read");
        end else begin
            checks++;
            if (cfg_rdata !== expv) begin
                report_mismatch(name, 64'(expv), 64'(cfg_rdata));
            end
        end
    endtask

    // Each return must line up with the read issued two cycles before.
    task automatic check_read_return();
        read_exp_t e;
        if (rd_valid) begin
            if (exp_q.size() == 0 || exp_q[0].cyc + 32'd2 != cyc) begin
                errors++;
                $display("rd_valid at t=%0t without a read issued two cycles earlier", $time);
            end else begin
                e = exp_q.pop_front();
                checks++;
                if (rd_data !== e.data) begin
                    report_mismatch("rd_data", 64'(e.data), 64'(rd_data));
                end
                if (sbit_err !== e.sbit) begin
                    report_mismatch("sbit_err", 64'(e.sbit), 64'(sbit_err));
                end
                if (dbit_err !== e.dbit) begin
                    report_mismatch("dbit_err", 64'(e.dbit), 64'(dbit_err));
                end
                count_error(e.sbit, e.dbit, e.addr);
            end
        end else if (exp_q.size() != 0 && exp_q[0].cyc + 32'd2 <= cyc) begin
            e = exp_q.pop_front();
            errors++;
            $display("rd_valid missing at t=%0t for the read of address %0d", $time, e.addr);
        end
    endtask

    always @(negedge clk) begin
        if (!rst) begin
            check_read_return();
        end
    end

    task automatic finish_test(input string name, input int start_errors);
        $display("Test %s finished with %0d errors", name, errors - start_errors);
    endtask

    initial begin
        int    start_errors;
        int    n;
        int    r0;
        int    r1;
        addr_t a;
        seed      = 32'h6450_a6c7;
        cyc       = 32'd0;
        checks    = 0;
        errors    = 0;
        rst       = 1'b1;
        wr_req    = 1'b0;
        wr_addr   = '0;
        wr_data   = '0;
        rd_req    = 1'b0;
        rd_addr   = '0;
        cfg_wr    = 1'b0;
        cfg_rd    = 1'b0;
        cfg_addr  = '0;
        cfg_wdata = 32'd0;
        reset_model();
        repeat (16) @(posedge clk);
        #1;
        rst = 1'b0;
        next_cycle();

        start_errors = errors;
        checks++;
        if (sbit_err !== 1'b0) begin
            report_mismatch("sbit_err", 64'd0, 64'(sbit_err));
        end
        if (dbit_err !== 1'b0) begin
            report_mismatch("dbit_err", 64'd0, 64'(dbit_err));
        end
        if (cfg_rvalid !== 1'b0) begin
            report_mismatch("cfg_rvalid", 64'd0, 64'(cfg_rvalid));
        end
        cfg_read_check(CSR_CTRL, "ctrl");
        cfg_read_check(CSR_INJ, "inj");
        cfg_read_check(CSR_SBIT_CNT, "sbit_cnt");
        cfg_read_check(CSR_DBIT_CNT, "dbit_cnt");
        cfg_read_check(CSR_LAST_ERR, "last_err");
        finish_test("reset_values", start_errors);

        start_errors = errors;
        for (n = 0; n < 64; n++) begin
            write_word(addr_t'(n), rand_data());
        end
        for (n = 0; n < 128; n++) begin
            queue_read(rand_addr());  // Back to back.
            next_cycle();
        end
        rd_req = 1'b0;
        drain_reads();
        finish_test("clean_write_read", start_errors);

        start_errors = errors;
        for (n = 0; n < 20; n++) begin
            r0 = $unsigned($random(seed)) % 69;
            cfg_write(CSR_INJ, {17'd0, 7'h7f, 1'b0, 7'(r0)});
            cfg_write(CSR_CTRL, 32'h2);
            a = rand_addr();
            write_word(a, rand_data());
            read_word(a);
            drain_reads();
            cfg_read_check(CSR_CTRL, "ctrl.inject_arm");
        end
        cfg_read_check(CSR_SBIT_CNT, "sbit_cnt");
        finish_test("single_bit_correction", start_errors);

        start_errors = errors;
        for (n = 0; n < 20; n++) begin
            r0 = $unsigned($random(seed)) % 69;
            r1 = (r0 + 1 + $unsigned($random(seed)) % 68) % 69;  // Distinct from r0.
            cfg_write(CSR_INJ, {17'd0, 7'(r1), 1'b0, 7'(r0)});
            cfg_write(CSR_CTRL, 32'h2);
            a = rand_addr();
            write_word(a, rand_data());
            read_word(a);
            drain_reads();
            cfg_read_check(CSR_CTRL, "ctrl.inject_arm");
        end
        cfg_read_check(CSR_DBIT_CNT, "dbit_cnt");
        finish_test("double_error_detection", start_errors);

        start_errors = errors;
        for (n = 0; n < 8; n++) begin
            r0 = $unsigned($random(seed)) % 69;
            r1 = $unsigned($random(seed)) % 69;
            cfg_write(CSR_INJ, {17'd0, 7'(r1), 1'b0, 7'(r0)});
            cfg_write(CSR_CTRL, 32'h3);
            a = rand_addr();
            write_word(a, rand_data());
            read_word(a);
            drain_reads();
            cfg_read_check(CSR_CTRL, "ctrl.inject_arm");
        end
        cfg_read_check(CSR_SBIT_CNT, "sbit_cnt");
        cfg_read_check(CSR_DBIT_CNT, "dbit_cnt");
        cfg_write(CSR_CTRL, 32'h0);
        finish_test("bypass", start_errors);

        start_errors = errors;
        cfg_read_check(CSR_LAST_ERR, "last_err");
        cfg_read_check(CSR_INJ, "inj");
        for (n = 5; n < 8; n++) begin
            cfg_read_check(csr_addr_t'(n), "unmapped");
        end
        cfg_write(CSR_SBIT_CNT, 32'h0);
        cfg_read_check(CSR_SBIT_CNT, "sbit_cnt");
        cfg_read_check(CSR_DBIT_CNT, "dbit_cnt");
        cfg_write(CSR_DBIT_CNT, 32'h0);
        cfg_read_check(CSR_DBIT_CNT, "dbit_cnt");
        for (n = 0; n < 8; n++) begin
            a = rand_addr();
            write_and_read(a, rand_data());
            read_word(a);
            drain_reads();
        end
        cfg_read_check(CSR_LAST_ERR, "last_err");
        finish_test("register_state", start_errors);

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== src/ecc_mem_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module ecc_mem_top (
    input  wire                    clk,
    input  wire                    rst,
    input  wire                    wr_req,
    input  wire ecc_pkg::addr_t    wr_addr,
    input  wire ecc_pkg::data_t    wr_data,
    input  wire                    rd_req,
    input  wire ecc_pkg::addr_t    rd_addr,
    output logic                   rd_valid,
    output ecc_pkg::data_t         rd_data,
    output logic                   sbit_err,
    output logic                   dbit_err,
    input  wire                    cfg_wr,
    input  wire                    cfg_rd,
    input  wire ecc_pkg::csr_addr_t cfg_addr,
    input  wire [31:0]             cfg_wdata,
    output logic                   cfg_rvalid,
    output logic [31:0]            cfg_rdata
);

    import ecc_pkg::*;

    logic       ram_we;
    addr_t      ram_waddr;
    cw_t        ram_wdata;
    addr_t      ram_raddr;
    cw_t        ram_rdata;
    data_t      enc_data;
    chk_t       enc_chk;
    cw_t        dec_cw;
    data_t      dec_data;
    logic       dec_sbit;
    logic       dec_dbit;
    logic       bypass;
    logic       inject_arm;
    logic [6:0] inj_pos0;
    logic [6:0] inj_pos1;
    logic       inj_done;
    addr_t      err_addr;

    ecc_mem_ctrl u_ctrl (
        .clk        (clk),
        .rst        (rst),
        .wr_req     (wr_req),
        .wr_addr    (wr_addr),
        .wr_data    (wr_data),
        .rd_req     (rd_req),
        .rd_addr    (rd_addr),
        .rd_valid   (rd_valid),
        .rd_data    (rd_data),
        .sbit_err   (sbit_err),
        .dbit_err   (dbit_err),
        .err_addr   (err_addr),
        .ram_we     (ram_we),
        .ram_waddr  (ram_waddr),
        .ram_wdata  (ram_wdata),
        .ram_raddr  (ram_raddr),
        .ram_rdata  (ram_rdata),
        .enc_data   (enc_data),
        .enc_chk    (enc_chk),
        .dec_cw     (dec_cw),
        .dec_data   (dec_data),
        .dec_sbit   (dec_sbit),
        .dec_dbit   (dec_dbit),
        .inject_arm (inject_arm),
        .inj_pos0   (inj_pos0),
        .inj_pos1   (inj_pos1),
        .inj_done   (inj_done)
    );

    ecc_word_ram u_ram (
        .clk   (clk),
        .we    (ram_we),
        .waddr (ram_waddr),
        .wdata (ram_wdata),
        .raddr (ram_raddr),
        .rdata (ram_rdata)
    );

    secded_61_codec u_codec (
        .enc_data (enc_data),
        .enc_chk  (enc_chk),
        .dec_cw   (dec_cw),
        .bypass   (bypass),
        .dec_data (dec_data),
        .sbit_err (dec_sbit),
        .dec_err  (dec_dbit)
    );

    // Error events come from the registered read return.
    ecc_csr u_csr (
        .clk        (clk),
        .rst        (rst),
        .cfg_wr     (cfg_wr),
        .cfg_rd     (cfg_rd),
        .cfg_addr   (cfg_addr),
        .cfg_wdata  (cfg_wdata),
        .cfg_rvalid (cfg_rvalid),
        .cfg_rdata  (cfg_rdata),
        .bypass     (bypass),
        .inject_arm (inject_arm),
        .inj_pos0   (inj_pos0),
        .inj_pos1   (inj_pos1),
        .inj_done   (inj_done),
        .err_valid  (rd_valid),
        .err_sbit   (sbit_err),
        .err_dbit   (dbit_err),
        .err_addr   (err_addr)
    );

endmodule

`default_nettype wire

// ==== src/ecc_mem_ctrl.sv ====
`timescale 1ns/10ps
`default_nettype none

module ecc_mem_ctrl (
    input  wire                 clk,
    input  wire                 rst,
    input  wire                 wr_req,
    input  wire ecc_pkg::addr_t wr_addr,
    input  wire ecc_pkg::data_t wr_data,
    input  wire                 rd_req,
    input  wire ecc_pkg::addr_t rd_addr,
    output logic                rd_valid,
    output ecc_pkg::data_t      rd_data,
    output logic                sbit_err,
    output logic                dbit_err,
    output ecc_pkg::addr_t      err_addr,
    output logic                ram_we,
    output ecc_pkg::addr_t      ram_waddr,
    output ecc_pkg::cw_t        ram_wdata,
    output ecc_pkg::addr_t      ram_raddr,
    input  wire ecc_pkg::cw_t   ram_rdata,
    output ecc_pkg::data_t      enc_data,
    input  wire ecc_pkg::chk_t  enc_chk,
    output ecc_pkg::cw_t        dec_cw,
    input  wire ecc_pkg::data_t dec_data,
    input  wire                 dec_sbit,
    input  wire                 dec_dbit,
    input  wire                 inject_arm,
    input  wire [6:0]           inj_pos0,
    input  wire [6:0]           inj_pos1,
    output logic                inj_done
);

    import ecc_pkg::*;

    localparam int CW_W = $bits(cw_t);

    cw_t   inj_mask;
    logic  rd_vld_s1;
    addr_t rd_addr_s1;

    // Equal positions cancel, out-of-range ones never match.
    always_comb begin
        inj_mask = '0;
        if (inject_arm) begin
            for (int j = 0; j < CW_W; j++) begin
                inj_mask[j] = (inj_pos0 == 7'(j)) ^ (inj_pos1 == 7'(j));
            end
        end
    end

    assign enc_data  = wr_data;
    assign ram_we    = wr_req;
    assign ram_waddr = wr_addr;
    assign ram_wdata = {enc_chk, wr_data} ^ inj_mask;
    assign inj_done  = wr_req && inject_arm;

    assign ram_raddr = rd_addr;
    assign dec_cw    = ram_rdata;  // Stage 1 output of the RAM.

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_vld_s1 <= 1'b0;
            rd_valid  <= 1'b0;
            sbit_err  <= 1'b0;
            dbit_err  <= 1'b0;
        end else begin
            rd_vld_s1 <= rd_req;
            rd_valid  <= rd_vld_s1;
            sbit_err  <= rd_vld_s1 && dec_sbit;
            dbit_err  <= rd_vld_s1 && dec_dbit;
        end
    end

    // Payload follows valid.
    always_ff @(posedge clk) begin
        rd_addr_s1 <= rd_addr;
        rd_data    <= dec_data;
        err_addr   <= rd_addr_s1;
    end

endmodule

`default_nettype wire

// ==== src/ecc_csr.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "ecc_params.svh"

module ecc_csr (
    input  wire                    clk,
    input  wire                    rst,
    input  wire                    cfg_wr,
    input  wire                    cfg_rd,
    input  wire ecc_pkg::csr_addr_t cfg_addr,
    input  wire [31:0]             cfg_wdata,
    output logic                   cfg_rvalid,
    output logic [31:0]            cfg_rdata,
    output logic                   bypass,
    output logic                   inject_arm,
    output logic [6:0]             inj_pos0,
    output logic [6:0]             inj_pos1,
    input  wire                    inj_done,
    input  wire                    err_valid,
    input  wire                    err_sbit,
    input  wire                    err_dbit,
    input  wire ecc_pkg::addr_t    err_addr
);

    import ecc_pkg::*;

    cnt_t        sbit_cnt;
    cnt_t        dbit_cnt;
    addr_t       last_err_addr;
    logic        last_err_vld;
    logic [31:0] rd_mux;

    always_ff @(posedge clk) begin
        if (rst) begin
            bypass     <= 1'b0;
            inject_arm <= 1'b0;
            inj_pos0   <= 7'h7f;  // No flip.
            inj_pos1   <= 7'h7f;
        end else begin
            if (inj_done) begin
                inject_arm <= 1'b0;  // One-shot.
            end
            if (cfg_wr && cfg_addr == CSR_CTRL) begin
                bypass     <= cfg_wdata[0];
                inject_arm <= cfg_wdata[1];
            end
            if (cfg_wr && cfg_addr == CSR_INJ) begin
                inj_pos0 <= cfg_wdata[6:0];
                inj_pos1 <= cfg_wdata[14:8];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            sbit_cnt      <= '0;
            dbit_cnt      <= '0;
            last_err_addr <= '0;
            last_err_vld  <= 1'b0;
        end else begin
            if (cfg_wr && cfg_addr == CSR_SBIT_CNT) begin
                sbit_cnt <= '0;
            end else if (err_valid && err_sbit && sbit_cnt != '1) begin
                sbit_cnt <= sbit_cnt + 1'b1;
            end
            if (cfg_wr && cfg_addr == CSR_DBIT_CNT) begin
                dbit_cnt <= '0;
            end else if (err_valid && err_dbit && dbit_cnt != '1) begin
                dbit_cnt <= dbit_cnt + 1'b1;
            end
            if (err_valid && (err_sbit || err_dbit)) begin
                last_err_addr <= err_addr;
                last_err_vld  <= 1'b1;
            end
        end
    end

    always_comb begin
        case (cfg_addr)
            CSR_CTRL:     rd_mux = {30'd0, inject_arm, bypass};
            CSR_INJ:      rd_mux = {17'd0, inj_pos1, 1'b0, inj_pos0};
            CSR_SBIT_CNT: rd_mux = {{(32-`ECC_CNT_W){1'b0}}, sbit_cnt};
            CSR_DBIT_CNT: rd_mux = {{(32-`ECC_CNT_W){1'b0}}, dbit_cnt};
            CSR_LAST_ERR: rd_mux = {last_err_vld, {(31-`ECC_ADDR_W){1'b0}}, last_err_addr};
            default:      rd_mux = 32'd0;  // Unmapped.
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            cfg_rvalid <= 1'b0;
        end else begin
            cfg_rvalid <= cfg_rd;
        end
    end

    always_ff @(posedge clk) begin
        if (cfg_rd) begin
            cfg_rdata <= rd_mux;
        end
    end

endmodule

`default_nettype wire

// ==== src/ecc_word_ram.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "ecc_params.svh"

module ecc_word_ram (
    input  wire                 clk,
    input  wire                 we,
    input  wire ecc_pkg::addr_t waddr,
    input  wire ecc_pkg::cw_t   wdata,
    input  wire ecc_pkg::addr_t raddr,
    output ecc_pkg::cw_t        rdata
);

    import ecc_pkg::*;

    localparam int DEPTH = 1 << `ECC_ADDR_W;

    cw_t mem [DEPTH];

    // Read returns the word as it was before a same-cycle write.
    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
        rdata <= mem[raddr];
    end

endmodule

`default_nettype wire

// ==== src/secded_61_codec.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "ecc_params.svh"

module secded_61_codec (
    input  wire ecc_pkg::data_t enc_data,
    output ecc_pkg::chk_t       enc_chk,
    input  wire ecc_pkg::cw_t   dec_cw,
    input  wire                 bypass,
    output ecc_pkg::data_t      dec_data,
    output logic                sbit_err,
    output logic                dec_err
);

    import ecc_pkg::*;

    localparam int CW_W = `ECC_DATA_W + `ECC_CHK_W;

    data_t stored_data;
    chk_t  stored_chk;
    chk_t  syndrome;
    data_t flip_mask;
    logic  single_err;
    logic  double_err;

    // Data bit i sits at the i-th Hamming position that is not a power of two.
    function automatic chk_t calc_chk(input data_t d);
        chk_t c;
        int   idx;
        c   = '0;
        idx = 0;
        for (int p = 3; p < CW_W; p++) begin
            if ((p & (p - 1)) != 0) begin
                for (int k = 0; k < `ECC_CHK_W - 1; k++) begin
                    if (p[k]) begin
                        c[k] = c[k] ^ d[idx];
                    end
                end
                idx++;
            end
        end
        c[`ECC_CHK_W-1] = (^d) ^ (^c[`ECC_CHK_W-2:0]);  // Overall parity.
        return c;
    endfunction

    assign enc_chk = calc_chk(enc_data);

    assign stored_data = dec_cw[`ECC_DATA_W-1:0];
    assign stored_chk  = dec_cw[CW_W-1:`ECC_DATA_W];
    assign syndrome    = stored_chk ^ calc_chk(stored_data);

    // Match against each data bit's column.
    always_comb begin
        flip_mask = '0;
        for (int i = 0; i < `ECC_DATA_W; i++) begin
            flip_mask[i] = (syndrome == calc_chk(data_t'(1) << i));
        end
    end

    // A lone syndrome bit is a flipped check bit.
    assign single_err = (|flip_mask) || $onehot(syndrome);
    assign double_err = (syndrome != '0) && !single_err;

    assign dec_data = bypass ? stored_data : (stored_data ^ flip_mask);
    assign sbit_err = !bypass && single_err;
    assign dec_err  = !bypass && double_err;

endmodule

`default_nettype wire

// ==== src/ecc_pkg.sv ====
`default_nettype none

package ecc_pkg;

`include "ecc_params.svh"

    typedef logic [`ECC_DATA_W-1:0]              data_t;
    typedef logic [`ECC_CHK_W-1:0]               chk_t;
    typedef logic [`ECC_DATA_W+`ECC_CHK_W-1:0]   cw_t;    // Check bits on top.
    typedef logic [`ECC_ADDR_W-1:0]              addr_t;
    typedef logic [`ECC_CNT_W-1:0]               cnt_t;
    typedef logic [2:0]                          csr_addr_t;

    // Register map.
    localparam csr_addr_t CSR_CTRL     = 3'd0;
    localparam csr_addr_t CSR_INJ      = 3'd1;
    localparam csr_addr_t CSR_SBIT_CNT = 3'd2;
    localparam csr_addr_t CSR_DBIT_CNT = 3'd3;
    localparam csr_addr_t CSR_LAST_ERR = 3'd4;

endpackage

`default_nettype wire

// ==== src/ecc_params.svh ====
`ifndef ECC_PARAMS_SVH
`define ECC_PARAMS_SVH

// Word layout.
`define ECC_DATA_W 61  // Data bits per word.
`define ECC_CHK_W  8   // Hamming bits plus overall parity.

// Store depth is 1 << ECC_ADDR_W.
`define ECC_ADDR_W 6

// Width of the saturating error counters.
`define ECC_CNT_W  16

`endif
